// File: list.f
source/coco_glue_pkg.sv
source/machine_control.sv
source/adc_tape_slicer.sv
source/tape_audio_mixer.sv
source/joystick_router.sv
source/coco_glue_top.sv
verif/coco_glue_checker.sv
verif/coco_glue_tb.sv

// File: Bender.yml
package:
  name: coco_glue

sources:
  - source/coco_glue_pkg.sv
  - source/machine_control.sv
  - source/adc_tape_slicer.sv
  - source/tape_audio_mixer.sv
  - source/joystick_router.sv
  - source/coco_glue_top.sv
  - target: test
    files:
      - verif/coco_glue_checker.sv
      - verif/coco_glue_tb.sv

// File: verif/coco_glue_tb.sv
// Testbench for the cassette and control glue
// Drives the slicer with a noisy two level tape signal, restarts the
// window on a machine change, pulses hard reset and checks audio,
// joystick routing, machine decode and turbo against reference models

`timescale 1ns/1ps

module coco_glue_tb;

	localparam int CLK_PERIOD = 40;
	localparam int WIN = 1 << coco_glue_pkg::WIN_LOG2;
	localparam int N_SAMPLES = 1500;
	localparam int SAMPLE_GAP = 6;
	localparam int RESTART_AT = 900;
	localparam int N_AUDIO = 200;
	localparam int N_JOY = 100;
	localparam int SETTLE = 24;
	localparam int TEST_CYCLES = 4 + N_SAMPLES * SAMPLE_GAP + (N_AUDIO + N_JOY + 4) * 2
		+ 5 * SETTLE;
	// Which outputs the compare process looks at
	localparam logic [4:0] CHK_SLICE = 5'b00001;
	localparam logic [4:0] CHK_AUDIO = 5'b00010;
	localparam logic [4:0] CHK_JOY = 5'b00100;
	localparam logic [4:0] CHK_MACH = 5'b01000;
	localparam logic [4:0] CHK_TURBO = 5'b10000;

	logic clk_sys;
	logic i_arst_n;
	logic [coco_glue_pkg::MSEL_W-1:0] i_machine_sel;
	logic i_hard_reset_tgl, i_disk_cart, i_turbo_en, i_cas_relay, i_soft_reset;
	logic o_dragon, o_dragon64, o_disk_cart, o_hard_reset, o_core_reset, o_turbo;
	logic i_adc_sync;
	logic [coco_glue_pkg::ADC_W-1:0] i_adc_data, o_adc_value;
	logic i_tape_src_adc, i_tape_monitor, i_file_cas_bit, i_snd_bit, o_cas_bit;
	logic [coco_glue_pkg::SND_W-1:0] i_sound;
	logic [coco_glue_pkg::AUDIO_W-1:0] o_audio;
	logic i_joy_swap;
	logic [coco_glue_pkg::JOY_W-1:0] i_joy1, i_joy2, o_joy1, o_joy2;
	logic [coco_glue_pkg::AJOY_W-1:0] i_joya1, i_joya2, o_joya1, o_joya2;

	// Expected values, set by the stimulus before each check
	logic [4:0] chk_mask = '0;
	logic [31:0] exp_value, exp_audio, exp_joy1, exp_joy2, exp_joya1, exp_joya2;
	logic exp_cas, exp_dragon, exp_dragon64, exp_turbo, exp_disk;
	int errors = 0;

	// Slicer model state
	int mdl_total, mdl_avg, mdl_value, mdl_fill, mdl_ptr;
	logic mdl_bit;
	int mdl_hist [WIN];

	// Reset activity seen on the outputs
	int run_len = 0;
	int last_stretch = 0;
	int stretches = 0;
	int hard_pulses = 0;
	int stretch_base, pulse_base;

	integer seed;
	int i, c, level, data, tape;

	coco_glue_top coco_glue_top_i (.*);

	initial
	begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////
	// Reference models
	////////////////////////////////////////////////////////////

	// Low input sets the tape bit, high input clears it
	function automatic logic slice_bit(input int val, input int avg, input logic cur);
		if (val + coco_glue_pkg::ADC_HYST < avg)
			return 1'b1;
		if (val > avg + coco_glue_pkg::ADC_HYST)
			return 1'b0;
		return cur;
	endfunction

	function automatic logic [15:0] audio_word(input logic snd_bit, input logic [11:0] sound,
		input logic mon, input logic tape_bit);
		logic [15:0] w;
		w = 16'(sound) << 3;
		// Sound bit 5 lands on audio bit 8
		if (mon && tape_bit)
			w[8] = ~w[8];
		w[15] = snd_bit;
		return w;
	endfunction

	// Y in bits 15:8 and X in bits 7:0, out swapped and offset by 128
	function automatic logic [15:0] centre_joya(input logic [15:0] w);
		int x;
		int y;
		x = w & 255;
		y = (w >> 8) & 255;
		return 16'((((x + 128) % 256) << 8) | ((y + 128) % 256));
	endfunction

	// One sample event, everything computed from the old state
	task automatic step_model(input int new_data);
		int leave;
		leave = (mdl_fill >= WIN) ? mdl_hist[mdl_ptr] : 0;
		mdl_bit = slice_bit(mdl_value, mdl_avg, mdl_bit);
		mdl_avg = (mdl_total / WIN) % 4096;
		mdl_total = mdl_total - leave + mdl_value;
		mdl_hist[mdl_ptr] = mdl_value;
		mdl_ptr = (mdl_ptr + 1) % WIN;
		if (mdl_fill < WIN)
			mdl_fill++;
		mdl_value = new_data;
	endtask

	task automatic reset_model();
		mdl_total = 0;
		mdl_avg = 0;
		mdl_value = 0;
		mdl_fill = 0;
		mdl_bit = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Compare
	////////////////////////////////////////////////////////////

	task automatic report_mismatch(input string name, input logic [31:0] expv,
		input logic [31:0] actv);
		errors++;
		$display("Error at %0t ns: %s expected 0x%0h, actual 0x%0h", $time, name, expv, actv);
	endtask

	// Hold the mask over one falling edge
	task automatic request_check(input logic [4:0] mask);
		chk_mask = mask;
		@(negedge clk_sys);
		#1;
		chk_mask = '0;
	endtask

	always @(negedge clk_sys)
	begin
		if ((chk_mask & CHK_SLICE) != 0)
		begin
			if (o_adc_value !== exp_value[11:0])
				report_mismatch("o_adc_value", exp_value, o_adc_value);
			if (o_cas_bit !== exp_cas)
				report_mismatch("o_cas_bit", exp_cas, o_cas_bit);
		end
		if ((chk_mask & CHK_AUDIO) != 0)
		begin
			if (o_audio !== exp_audio[15:0])
				report_mismatch("o_audio", exp_audio, o_audio);
			if (o_cas_bit !== exp_cas)
				report_mismatch("o_cas_bit", exp_cas, o_cas_bit);
		end
		if ((chk_mask & CHK_JOY) != 0)
		begin
			if (o_joy1 !== exp_joy1)
				report_mismatch("o_joy1", exp_joy1, o_joy1);
			if (o_joy2 !== exp_joy2)
				report_mismatch("o_joy2", exp_joy2, o_joy2);
			if (o_joya1 !== exp_joya1[15:0])
				report_mismatch("o_joya1", exp_joya1, o_joya1);
			if (o_joya2 !== exp_joya2[15:0])
				report_mismatch("o_joya2", exp_joya2, o_joya2);
		end
		if ((chk_mask & CHK_MACH) != 0)
		begin
			if (o_dragon !== exp_dragon)
				report_mismatch("o_dragon", exp_dragon, o_dragon);
			if (o_dragon64 !== exp_dragon64)
				report_mismatch("o_dragon64", exp_dragon64, o_dragon64);
		end
		if ((chk_mask & CHK_TURBO) != 0)
		begin
			if (o_turbo !== exp_turbo)
				report_mismatch("o_turbo", exp_turbo, o_turbo);
			if (o_disk_cart !== exp_disk)
				report_mismatch("o_disk_cart", exp_disk, o_disk_cart);
		end
	end

	// Length of each core reset run and count of hard reset cycles
	always @(negedge clk_sys)
	begin
		if (o_core_reset === 1'b1)
			run_len++;
		else if (run_len != 0)
		begin
			last_stretch = run_len;
			stretches++;
			run_len = 0;
		end
		if (o_hard_reset === 1'b1)
			hard_pulses++;
	end

	task automatic print_summary();
		$display("Errors %0d, assertion failures %0d", errors,
			coco_glue_top_i.machine_control_i.control_checker_i.assert_fails);
	endtask

	initial
	begin
		repeat (2 * TEST_CYCLES) @(posedge clk_sys);
		$display("Error at %0t ns: watchdog expired before the tests completed", $time);
		print_summary();
		$display("Finished with errors");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial
	begin
		seed = 32'h7310_4472;
		i_arst_n = 1'b0;
		i_machine_sel = '0;
		i_hard_reset_tgl = 1'b0;
		i_disk_cart = 1'b0;
		i_turbo_en = 1'b0;
		i_cas_relay = 1'b0;
		i_soft_reset = 1'b0;
		i_adc_sync = 1'b0;
		i_adc_data = '0;
		i_tape_src_adc = 1'b1;
		i_tape_monitor = 1'b0;
		i_file_cas_bit = 1'b0;
		i_sound = '0;
		i_snd_bit = 1'b0;
		i_joy_swap = 1'b0;
		i_joy1 = '0;
		i_joy2 = '0;
		i_joya1 = '0;
		i_joya2 = '0;
		reset_model();
		mdl_ptr = 0;
		repeat (4) @(posedge clk_sys);
		i_arst_n <= 1'b1;

		// Tape stream, eight samples per level, machine change midway
		for (i = 0; i < N_SAMPLES; i++)
		begin
			if ((i % 8) == 0)
				level = (((i / 8) % 2) != 0) ? 2600 + {$random(seed)} % 800
					: 600 + {$random(seed)} % 800;
			data = level + {$random(seed)} % 121 - 60;
			@(posedge clk_sys);
			i_adc_data <= data[11:0];
			i_adc_sync <= ~i_adc_sync;
			step_model(data);
			if (i == RESTART_AT)
			begin
				i_machine_sel <= 2'd1;
				stretch_base = stretches;
				// Restart lands after this sample event
				reset_model();
			end
			exp_value = mdl_value;
			exp_cas = mdl_bit;
			repeat (SAMPLE_GAP - 1) @(posedge clk_sys);
			request_check(CHK_SLICE);
		end
		if (stretches != stretch_base + 1)
			report_mismatch("o_core_reset runs", stretch_base + 1, stretches);
		if (last_stretch != coco_glue_pkg::RESET_STRETCH)
			report_mismatch("o_core_reset length", coco_glue_pkg::RESET_STRETCH, last_stretch);

		// Audio packing under both tape sources
		for (i = 0; i < N_AUDIO; i++)
		begin
			@(posedge clk_sys);
			i_sound <= $random(seed);
			i_snd_bit <= $random(seed);
			i_file_cas_bit <= $random(seed);
			i_tape_monitor <= $random(seed);
			i_tape_src_adc <= (i >= N_AUDIO / 2);
			@(posedge clk_sys);
			tape = i_tape_src_adc ? mdl_bit : i_file_cas_bit;
			exp_cas = tape[0];
			exp_audio = audio_word(i_snd_bit, i_sound, i_tape_monitor, tape[0]);
			request_check(CHK_AUDIO);
		end

		// Hard reset toggle gives one pulse and one stretch
		stretch_base = stretches;
		pulse_base = hard_pulses;
		@(posedge clk_sys);
		i_hard_reset_tgl <= ~i_hard_reset_tgl;
		repeat (SETTLE) @(posedge clk_sys);
		if (hard_pulses != pulse_base + 1)
			report_mismatch("o_hard_reset cycles", pulse_base + 1, hard_pulses);
		if (stretches != stretch_base + 1)
			report_mismatch("o_core_reset runs", stretch_base + 1, stretches);
		if (last_stretch != coco_glue_pkg::RESET_STRETCH)
			report_mismatch("o_core_reset length", coco_glue_pkg::RESET_STRETCH, last_stretch);

		// Machine decode for CoCo2, Dragon32 and Dragon64
		for (c = 0; c < 3; c++)
		begin
			@(posedge clk_sys);
			i_machine_sel <= c[1:0];
			reset_model();
			exp_dragon = (c != 0);
			exp_dragon64 = (c == 2);
			@(posedge clk_sys);
			request_check(CHK_MACH);
			repeat (SETTLE - 2) @(posedge clk_sys);
		end

		// Joystick routing with random swap
		for (i = 0; i < N_JOY; i++)
		begin
			@(posedge clk_sys);
			i_joy1 <= $random(seed);
			i_joy2 <= $random(seed);
			i_joya1 <= $random(seed);
			i_joya2 <= $random(seed);
			i_joy_swap <= $random(seed);
			@(posedge clk_sys);
			exp_joy1 = i_joy_swap ? i_joy2 : i_joy1;
			exp_joy2 = i_joy_swap ? i_joy1 : i_joy2;
			exp_joya1 = centre_joya(i_joy_swap ? i_joya2 : i_joya1);
			exp_joya2 = centre_joya(i_joy_swap ? i_joya1 : i_joya2);
			request_check(CHK_JOY);
		end

		// Turbo needs both enable and relay
		for (c = 0; c < 4; c++)
		begin
			@(posedge clk_sys);
			i_turbo_en <= c[0];
			i_cas_relay <= c[1];
			i_disk_cart <= c[0] ^ c[1];
			exp_turbo = c[0] & c[1];
			exp_disk = c[0] ^ c[1];
			@(posedge clk_sys);
			request_check(CHK_TURBO);
		end

		// Soft reset reaches the core reset in the same cycle
		@(posedge clk_sys);
		i_soft_reset <= 1'b1;
		@(negedge clk_sys);
		if (o_core_reset !== 1'b1)
			report_mismatch("o_core_reset", 1, o_core_reset);
		@(posedge clk_sys);
		i_soft_reset <= 1'b0;
		@(negedge clk_sys);
		if (o_core_reset !== 1'b0)
			report_mismatch("o_core_reset", 0, o_core_reset);

		repeat (4) @(posedge clk_sys);
		print_summary();
		if (errors == 0 && coco_glue_top_i.machine_control_i.control_checker_i.assert_fails == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: verif/coco_glue_checker.sv
// Control output checks for machine control
// Concurrent assertions on the hard reset pulse, the window restart
// strobe and turbo gating, bound into every machine_control

`timescale 1ns/1ps

module coco_glue_checker (
	input logic clk_sys,
	input logic i_arst_n,
	input logic i_turbo_en,
	input logic o_hard_reset,
	input logic o_window_restart,
	input logic o_turbo
);

	// Read by the testbench summary
	int assert_fails = 0;

	////////////////////////////////////////////////////////////
	// Pulse shapes
	////////////////////////////////////////////////////////////

	// Hard reset is a single cycle
	hard_reset_single : assert property (@(posedge clk_sys) disable iff (!i_arst_n)
		o_hard_reset |=> !o_hard_reset)
	else
	begin
		$error("o_hard_reset high for two consecutive cycles");
		assert_fails++;
	end

	restart_single : assert property (@(posedge clk_sys) disable iff (!i_arst_n)
		o_window_restart |=> !o_window_restart)
	else
	begin
		$error("o_window_restart longer than one cycle");
		assert_fails++;
	end

	// Turbo follows its enable by one register
	turbo_needs_enable : assert property (@(posedge clk_sys) disable iff (!i_arst_n)
		o_turbo |-> $past(i_turbo_en))
	else
	begin
		$error("o_turbo without i_turbo_en on the previous cycle");
		assert_fails++;
	end

endmodule

bind machine_control coco_glue_checker control_checker_i (
	.clk_sys          (clk_sys),
	.i_arst_n         (i_arst_n),
	.i_turbo_en       (i_turbo_en),
	.o_hard_reset     (o_hard_reset),
	.o_window_restart (o_window_restart),
	.o_turbo          (o_turbo)
);

// File: source/coco_glue_top.sv
// Cassette and control glue top level
// Joins machine control, the tape ADC slicer, the audio mixer
// and the joystick router around the home computer core

`timescale 1ns/1ps

module coco_glue_top (
	input  logic                              clk_sys,
	input  logic                              i_arst_n,
	// Machine control
	input  logic [coco_glue_pkg::MSEL_W-1:0]  i_machine_sel,
	input  logic                              i_hard_reset_tgl,
	input  logic                              i_disk_cart,
	input  logic                              i_turbo_en,
	input  logic                              i_cas_relay,
	input  logic                              i_soft_reset,
	output logic                              o_dragon,
	output logic                              o_dragon64,
	output logic                              o_disk_cart,
	output logic                              o_hard_reset,
	output logic                              o_core_reset,
	output logic                              o_turbo,
	// Tape ADC
	input  logic                              i_adc_sync,
	input  logic [coco_glue_pkg::ADC_W-1:0]   i_adc_data,
	output logic [coco_glue_pkg::ADC_W-1:0]   o_adc_value,
	// Tape and audio
	input  logic                              i_tape_src_adc,
	input  logic                              i_tape_monitor,
	input  logic                              i_file_cas_bit,
	input  logic [coco_glue_pkg::SND_W-1:0]   i_sound,
	input  logic                              i_snd_bit,
	output logic                              o_cas_bit,
	output logic [coco_glue_pkg::AUDIO_W-1:0] o_audio,
	// Joysticks
	input  logic                              i_joy_swap,
	input  logic [coco_glue_pkg::JOY_W-1:0]   i_joy1,
	input  logic [coco_glue_pkg::JOY_W-1:0]   i_joy2,
	input  logic [coco_glue_pkg::AJOY_W-1:0]  i_joya1,
	input  logic [coco_glue_pkg::AJOY_W-1:0]  i_joya2,
	output logic [coco_glue_pkg::JOY_W-1:0]   o_joy1,
	output logic [coco_glue_pkg::JOY_W-1:0]   o_joy2,
	output logic [coco_glue_pkg::AJOY_W-1:0]  o_joya1,
	output logic [coco_glue_pkg::AJOY_W-1:0]  o_joya2
);

	// Machine change clears the slicer history
	logic window_restart;
	// Sliced tape bit into the source select
	logic adc_bit;

	machine_control machine_control_i (
		.clk_sys          (clk_sys),
		.i_arst_n         (i_arst_n),
		.i_machine_sel    (i_machine_sel),
		.i_hard_reset_tgl (i_hard_reset_tgl),
		.i_disk_cart      (i_disk_cart),
		.i_turbo_en       (i_turbo_en),
		.i_cas_relay      (i_cas_relay),
		.i_soft_reset     (i_soft_reset),
		.o_dragon         (o_dragon),
		.o_dragon64       (o_dragon64),
		.o_disk_cart      (o_disk_cart),
		.o_hard_reset     (o_hard_reset),
		.o_core_reset     (o_core_reset),
		.o_window_restart (window_restart),
		.o_turbo          (o_turbo)
	);

	adc_tape_slicer adc_tape_slicer_i (
		.clk_sys          (clk_sys),
		.i_arst_n         (i_arst_n),
		.i_adc_sync       (i_adc_sync),
		.i_adc_data       (i_adc_data),
		.i_window_restart (window_restart),
		.o_adc_bit        (adc_bit),
		.o_adc_value      (o_adc_value)
	);

	tape_audio_mixer tape_audio_mixer_i (
		.clk_sys        (clk_sys),
		.i_arst_n       (i_arst_n),
		.i_tape_src_adc (i_tape_src_adc),
		.i_tape_monitor (i_tape_monitor),
		.i_adc_bit      (adc_bit),
		.i_file_cas_bit (i_file_cas_bit),
		.i_sound        (i_sound),
		.i_snd_bit      (i_snd_bit),
		.o_cas_bit      (o_cas_bit),
		.o_audio        (o_audio)
	);

	joystick_router joystick_router_i (
		.clk_sys    (clk_sys),
		.i_arst_n   (i_arst_n),
		.i_joy_swap (i_joy_swap),
		.i_joy1     (i_joy1),
		.i_joy2     (i_joy2),
		.i_joya1    (i_joya1),
		.i_joya2    (i_joya2),
		.o_joy1     (o_joy1),
		.o_joy2     (o_joy2),
		.o_joya1    (o_joya1),
		.o_joya2    (o_joya2)
	);

endmodule

// File: source/joystick_router.sv
// Joystick routing for the two player ports
// Optionally swaps the players and recentres the analog axes,
// analog output carries X in the high byte and Y in the low byte

`timescale 1ns/1ps

module joystick_router (
	input  logic                             clk_sys,
	input  logic                             i_arst_n,
	input  logic                             i_joy_swap,
	input  logic [coco_glue_pkg::JOY_W-1:0]  i_joy1,
	input  logic [coco_glue_pkg::JOY_W-1:0]  i_joy2,
	input  logic [coco_glue_pkg::AJOY_W-1:0] i_joya1,
	input  logic [coco_glue_pkg::AJOY_W-1:0] i_joya2,
	output logic [coco_glue_pkg::JOY_W-1:0]  o_joy1,
	output logic [coco_glue_pkg::JOY_W-1:0]  o_joy2,
	output logic [coco_glue_pkg::AJOY_W-1:0] o_joya1,
	output logic [coco_glue_pkg::AJOY_W-1:0] o_joya2
);

	// Players after the swap
	logic [coco_glue_pkg::AJOY_W-1:0] joya1_sel;
	logic [coco_glue_pkg::AJOY_W-1:0] joya2_sel;

	// Signed axis to offset binary, X and Y change places
	function automatic logic [coco_glue_pkg::AJOY_W-1:0] centre_axes(
		input logic [coco_glue_pkg::AJOY_W-1:0] joya
	);
		logic [7:0] x_c;
		logic [7:0] y_c;
		x_c = joya[7:0] + 8'd128;
		y_c = joya[15:8] + 8'd128;
		return {x_c, y_c};
	endfunction

	assign joya1_sel = i_joy_swap ? i_joya2 : i_joya1;
	assign joya2_sel = i_joy_swap ? i_joya1 : i_joya2;

	always_ff @(posedge clk_sys or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_joy1 <= '0;
			o_joy2 <= '0;
			o_joya1 <= '0;
			o_joya2 <= '0;
		end
		else
		begin
			o_joy1 <= i_joy_swap ? i_joy2 : i_joy1;
			o_joy2 <= i_joy_swap ? i_joy1 : i_joy2;
			o_joya1 <= centre_axes(joya1_sel);
			o_joya2 <= centre_axes(joya2_sel);
		end
	end

endmodule

// File: source/tape_audio_mixer.sv
// Tape source select and audio packing
// Picks the ADC or file tape bit and builds the 16 bit audio word,
// optionally mixing the tape bit in at a low level for monitoring

`timescale 1ns/1ps

module tape_audio_mixer (
	input  logic                              clk_sys,
	input  logic                              i_arst_n,
	input  logic                              i_tape_src_adc,
	input  logic                              i_tape_monitor,
	input  logic                              i_adc_bit,
	input  logic                              i_file_cas_bit,
	input  logic [coco_glue_pkg::SND_W-1:0]   i_sound,
	input  logic                              i_snd_bit,
	output logic                              o_cas_bit,
	output logic [coco_glue_pkg::AUDIO_W-1:0] o_audio
);

	logic tape_bit;
	logic mon_bit;

	// Tape source for the core and for the monitor
	assign tape_bit = i_tape_src_adc ? i_adc_bit : i_file_cas_bit;
	// Monitor flips sound bit 5
	assign mon_bit = i_sound[5] ^ (i_tape_monitor & tape_bit);

	always_ff @(posedge clk_sys or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_cas_bit <= 1'b0;
			o_audio <= '0;
		end
		else
		begin
			o_cas_bit <= tape_bit;
			// One bit sound loudest, then the core sound, low bits padded
			o_audio <= {i_snd_bit, i_sound[coco_glue_pkg::SND_W-1:6], mon_bit, i_sound[4:0],
				{(coco_glue_pkg::AUDIO_W - coco_glue_pkg::SND_W - 1){1'b0}}};
		end
	end

endmodule

// File: source/adc_tape_slicer.sv
// Tape input slicer for the cassette ADC
// Keeps a running average over the last 512 samples and slices each
// new sample against it with hysteresis, the bit goes high on low input
// like the original cassette port

`timescale 1ns/1ps

module adc_tape_slicer (
	input  logic                            clk_sys,
	input  logic                            i_arst_n,
	input  logic                            i_adc_sync,
	input  logic [coco_glue_pkg::ADC_W-1:0] i_adc_data,
	input  logic                            i_window_restart,
	output logic                            o_adc_bit,
	output logic [coco_glue_pkg::ADC_W-1:0] o_adc_value
);

	// Sample strobe from the toggling sync
	logic sync_q;
	logic sample_evt;

	// Circular window of past samples
	logic [coco_glue_pkg::ADC_W-1:0] win_mem [2**coco_glue_pkg::WIN_LOG2];
	logic [coco_glue_pkg::WIN_LOG2-1:0] wr_ptr;
	// Writes since restart, top bit set once the window is full
	logic [coco_glue_pkg::WIN_LOG2:0] fill_cnt;
	// Oldest entry, read ahead of the event
	logic [coco_glue_pkg::ADC_W-1:0] leave_q;
	logic [coco_glue_pkg::ADC_W-1:0] leave_val;

	// Running total and average
	logic [coco_glue_pkg::TOTAL_W-1:0] total_q;
	logic [coco_glue_pkg::TOTAL_W-1:0] leave_ext;
	logic [coco_glue_pkg::TOTAL_W-1:0] value_ext;
	logic [coco_glue_pkg::ADC_W-1:0] avg_q;

	// Hysteresis compares, one bit wider so nothing wraps
	logic [coco_glue_pkg::ADC_W:0] hyst_ext;
	logic [coco_glue_pkg::ADC_W:0] value_plus_hyst;
	logic [coco_glue_pkg::ADC_W:0] avg_plus_hyst;

	//////////////////////////////////////////////////////////////
	// Sample detect
	//////////////////////////////////////////////////////////////

	// Event fires the cycle after sync toggles
	always_ff @(posedge clk_sys or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			sync_q <= 1'b0;
			sample_evt <= 1'b0;
		end
		else
		begin
			sync_q <= i_adc_sync;
			sample_evt <= i_adc_sync ^ sync_q;
		end
	end

	//////////////////////////////////////////////////////////////
	// Window buffer
	//////////////////////////////////////////////////////////////

	// Old value goes in where the oldest one leaves
	always_ff @(posedge clk_sys)
	begin
		if (sample_evt)
			win_mem[wr_ptr] <= o_adc_value;
		leave_q <= win_mem[wr_ptr];
	end

	// Nothing leaves until 512 samples have gone in
	assign leave_val = fill_cnt[coco_glue_pkg::WIN_LOG2] ? leave_q : '0;

	assign leave_ext = {{(coco_glue_pkg::TOTAL_W - coco_glue_pkg::ADC_W){1'b0}}, leave_val};
	assign value_ext = {{(coco_glue_pkg::TOTAL_W - coco_glue_pkg::ADC_W){1'b0}}, o_adc_value};

	assign hyst_ext = (coco_glue_pkg::ADC_W + 1)'(coco_glue_pkg::ADC_HYST);
	assign value_plus_hyst = {1'b0, o_adc_value} + hyst_ext;
	assign avg_plus_hyst = {1'b0, avg_q} + hyst_ext;

	//////////////////////////////////////////////////////////////
	// Average and slicer
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			wr_ptr <= '0;
			fill_cnt <= '0;
			total_q <= '0;
			avg_q <= '0;
			o_adc_value <= '0;
			o_adc_bit <= 1'b0;
		end
		else if (i_window_restart)
		begin
			// Fresh history, pointer keeps going
			fill_cnt <= '0;
			total_q <= '0;
			avg_q <= '0;
			o_adc_value <= '0;
			o_adc_bit <= 1'b0;
		end
		else if (sample_evt)
		begin
			// Low input sets the bit, high input clears it
			if (value_plus_hyst < {1'b0, avg_q})
				o_adc_bit <= 1'b1;
			else if ({1'b0, o_adc_value} > avg_plus_hyst)
				o_adc_bit <= 1'b0;
			// Divide by 512
			avg_q <= total_q[coco_glue_pkg::WIN_LOG2 +: coco_glue_pkg::ADC_W];
			total_q <= total_q - leave_ext + value_ext;
			o_adc_value <= i_adc_data;
			wr_ptr <= wr_ptr + 1'b1;
			if (!fill_cnt[coco_glue_pkg::WIN_LOG2])
				fill_cnt <= fill_cnt + 1'b1;
		end
	end

endmodule

// File: source/machine_control.sv
// Machine control for the home computer core
// Decodes the machine select, stretches the core reset on a machine
// change, makes a one cycle hard reset pulse on each request toggle,
// restarts the tape window and gates turbo with the cassette relay

`timescale 1ns/1ps

module machine_control (
	input  logic                             clk_sys,
	input  logic                             i_arst_n,
	input  logic [coco_glue_pkg::MSEL_W-1:0] i_machine_sel,
	input  logic                             i_hard_reset_tgl,
	input  logic                             i_disk_cart,
	input  logic                             i_turbo_en,
	input  logic                             i_cas_relay,
	input  logic                             i_soft_reset,
	output logic                             o_dragon,
	output logic                             o_dragon64,
	output logic                             o_disk_cart,
	output logic                             o_hard_reset,
	output logic                             o_core_reset,
	output logic                             o_window_restart,
	output logic                             o_turbo
);

	// Registered copies of the change inputs
	logic [coco_glue_pkg::MSEL_W-1:0] msel_q;
	logic hard_tgl_q;
	// Change detect, valid for one cycle after an input edge
	logic msel_chg;
	logic hard_chg;
	// Second stage, lines the strobes up with the stretch start
	logic msel_chg_q;
	logic hard_pend;
	// Stretch counter and its registered flag
	logic [coco_glue_pkg::STRETCH_W-1:0] stretch_cnt;
	logic stretch_q;

	assign msel_chg = (i_machine_sel != msel_q);
	assign hard_chg = (i_hard_reset_tgl != hard_tgl_q);

	// Copies follow the inputs even while in reset
	// so the release of reset never looks like a change
	always_ff @(posedge clk_sys)
	begin
		msel_q <= i_machine_sel;
		hard_tgl_q <= i_hard_reset_tgl;
	end

	//////////////////////////////////////////////////////////////
	// Reset stretch and hard reset pulse
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			stretch_cnt <= '0;
			stretch_q <= 1'b0;
			msel_chg_q <= 1'b0;
			hard_pend <= 1'b0;
			o_hard_reset <= 1'b0;
			o_window_restart <= 1'b0;
		end
		else
		begin
			// Either change reloads the full length, a new change wins over counting
			if (msel_chg || hard_chg)
				stretch_cnt <= coco_glue_pkg::STRETCH_W'(coco_glue_pkg::RESET_STRETCH);
			else if (stretch_cnt != '0)
				stretch_cnt <= stretch_cnt - 1'b1;
			stretch_q <= (stretch_cnt != '0);
			// Window restart on the first stretch cycle of a machine change
			msel_chg_q <= msel_chg;
			o_window_restart <= msel_chg_q;
			// Hard reset lands with the stretch start
			hard_pend <= hard_chg;
			o_hard_reset <= hard_pend;
		end
	end

	// Soft reset from the host passes straight through
	assign o_core_reset = stretch_q | i_soft_reset;

	//////////////////////////////////////////////////////////////
	// Machine decode and turbo
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_dragon <= 1'b0;
			o_dragon64 <= 1'b0;
			o_disk_cart <= 1'b0;
			o_turbo <= 1'b0;
		end
		else
		begin
			// Dragon32 and Dragon64 both run the Dragon memory map
			o_dragon <= (i_machine_sel != coco_glue_pkg::MSEL_COCO2);
			o_dragon64 <= (i_machine_sel == coco_glue_pkg::MSEL_DRAGON64);
			o_disk_cart <= i_disk_cart;
			// Turbo only while the cassette relay is closed
			o_turbo <= i_turbo_en & i_cas_relay;
		end
	end

endmodule

// File: source/coco_glue_pkg.sv
// Cassette and control glue shared definitions
// Widths, window geometry, slicer thresholds and reset stretch length
// for the glue logic around the home computer core

package coco_glue_pkg;

	//////////////////////////////////////////////////////////////
	// Tape ADC path
	//////////////////////////////////////////////////////////////

	// One ADC sample
	localparam int ADC_W = 12;
	// Window of 512 samples for the running average
	localparam int WIN_LOG2 = 9;
	// Running total, wide enough for 512 full scale samples
	localparam int TOTAL_W = 22;
	// Distance from the average before the tape bit flips
	localparam int ADC_HYST = 100;

	//////////////////////////////////////////////////////////////
	// Audio and joysticks
	//////////////////////////////////////////////////////////////

	// Sound word from the core
	localparam int SND_W = 12;
	// Packed audio word to the codec
	localparam int AUDIO_W = 16;
	// Digital joystick buttons and directions
	localparam int JOY_W = 32;
	// Analog joystick, Y in the high byte, X in the low byte
	localparam int AJOY_W = 16;

	//////////////////////////////////////////////////////////////
	// Machine control
	//////////////////////////////////////////////////////////////

	// Machine select, 0 CoCo2, 1 Dragon32, 2 Dragon64
	localparam int MSEL_W = 2;
	localparam logic [MSEL_W-1:0] MSEL_COCO2 = 2'd0;
	localparam logic [MSEL_W-1:0] MSEL_DRAGON64 = 2'd2;
	// Core reset length after a machine change
	localparam int RESET_STRETCH = 15;
	localparam int STRETCH_W = $clog2(RESET_STRETCH + 1);

endpackage
